/* dzMux.f */
rtl/dzPkg.sv
rtl/dzIntrIf.sv
rtl/dzRegs.sv
rtl/dzRxSilo.sv
rtl/dzIntr.sv
rtl/dzMux.sv
testbench/dzMuxChecker.sv
testbench/dzMuxTb.sv

/* build.sh */
#!/bin/sh
# Compile the DZ multiplexer testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module dzMuxTb \
   -f dzMux.f -o dzMuxSim &&
{
   simOut="$(./obj_dir/dzMuxSim)"
   printf '%s\n' "$simOut"
   printf '%s\n' "$simOut" | grep -q "TB PASSED"
} ||
{ echo "simulation did not pass"; exit 1; }

/* testbench/dzMuxTb.sv */
////////////////////////////////////////
// DZ multiplexer testbench
// Stimulus table over APB, lines, transmitter and interrupt bus
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dzMuxTb;

   import dzPkg::*;

   localparam int          SILO_DEPTH = 16;
   localparam logic [8:0]  VEC_BASE   = 9'o300;
   localparam int          WAIT_LIMIT = 5;
   localparam logic [15:0] CSR_IDLE   = 16'h8000;

   typedef enum logic [2:0] {
      doWrite, doRead, doChar, doTxReady, doIack, doVector, expIntr, expTx
   } stepKindT;

   // One table row with the expected response packed in expv
   typedef struct packed {
      stepKindT    kind;
      logic [7:0]  test;
      regAddrT     addr;
      logic [15:0] data;
      logic [16:0] expv;
   } stepT;

   // DUT ports
   logic        clk;
   logic        rst;
   regAddrT     paddr;
   logic        psel;
   logic        penable;
   logic        pwrite;
   logic [15:0] pwdata;
   logic [15:0] prdata;
   logic        pready;
   logic        pslverr;
   logic        iack;
   logic        vectRead;
   logic        rxIntr;
   logic        txIntr;
   logic [8:0]  intrVector;
   logic        rxValid;
   lineT        rxLine;
   charT        rxData;
   logic        txReady;
   logic        txValid;
   lineT        txLine;
   charT        txData;

   // Checker handshake
   logic        rdChk;
   logic        vecChk;
   logic        intrChk;
   logic        txChk;
   logic [16:0] expVal;
   logic [7:0]  testNum;
   logic [31:0] stepNum;
   logic        runDone;
   logic        reportDone;
   int          checkCount;
   int          errorCount;
   int          testCount;

   stepT        steps [$];
   logic [31:0] lcgState;
   int          numChecks;
   int          cycleLimit;
   int          cycleCount = 0;

   dzMux #(.SILO_DEPTH(SILO_DEPTH), .VECTOR_BASE(VEC_BASE)) dzMux_i (
      .clk(clk), .rst(rst),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .iack(iack), .vectRead(vectRead), .rxIntr(rxIntr), .txIntr(txIntr),
      .intrVector(intrVector),
      .rxValid(rxValid), .rxLine(rxLine), .rxData(rxData),
      .txReady(txReady), .txValid(txValid), .txLine(txLine), .txData(txData)
   );

   dzMuxChecker responseChecker (
      .clk(clk), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .txValid(txValid), .txLine(txLine), .txData(txData),
      .rxIntr(rxIntr), .txIntr(txIntr), .intrVector(intrVector),
      .rdChk(rdChk), .vecChk(vecChk), .intrChk(intrChk), .txChk(txChk),
      .expVal(expVal), .testNum(testNum), .stepNum(stepNum), .runDone(runDone),
      .reportDone(reportDone), .checkCount(checkCount), .errorCount(errorCount),
      .testCount(testCount)
   );

   // 100 ns clock
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;
   end

   ////////////////////////////////////////
   // Table construction
   ////////////////////////////////////////

   function automatic logic [31:0] lcgNext(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   // Random line and character
   task automatic nextEntry(output siloEntryT e);
      lcgState = lcgNext(lcgState);
      e = {lcgState[26:24], lcgState[23:16]};
   endtask

   // RBUF image of a waiting character with no slave error
   function automatic logic [16:0] rbufOf(input siloEntryT e);
      return {1'b0, 16'(1 << RBUF_VALID) | {5'd0, e}};
   endfunction

   task automatic addStep(input stepKindT kind, input int test, input regAddrT addr,
                          input logic [15:0] data, input logic [16:0] expv);
      stepT s;
      s.kind = kind;
      s.test = 8'(test);
      s.addr = addr;
      s.data = data;
      s.expv = expv;
      steps.push_back(s);
      if (kind inside {doRead, doVector, expIntr, expTx})
         numChecks++;
   endtask

   task automatic buildTable();
      siloEntryT ent [17];
      siloEntryT e;
      // Test 1 covers the reset value and an unmapped offset
      addStep(doRead, 1, CSR_ADDR, '0, {1'b0, CSR_IDLE});
      addStep(doRead, 1, 4'd12, '0, {1'b1, 16'h0000});
      // Test 2 covers silo order and overflow
      for (int k = 0; k < 5; k++)
      begin
         nextEntry(ent[k]);
         addStep(doChar, 2, '0, {5'd0, ent[k]}, '0);
      end
      for (int k = 0; k < 5; k++)
         addStep(doRead, 2, RBUF_ADDR, '0, rbufOf(ent[k]));
      addStep(doRead, 2, RBUF_ADDR, '0, '0);
      for (int k = 0; k < SILO_DEPTH + 1; k++)
      begin
         nextEntry(ent[k]);
         addStep(doChar, 2, '0, {5'd0, ent[k]}, '0);
      end
      for (int k = 0; k < SILO_DEPTH; k++)
         addStep(doRead, 2, RBUF_ADDR, '0, rbufOf(ent[k]));
      addStep(doRead, 2, RBUF_ADDR, '0, '0);
      // Test 3 covers the transmit hold and back-pressure
      nextEntry(e);
      addStep(doWrite, 3, TDR_ADDR, {5'd0, e}, '0);
      addStep(expTx, 3, '0, '0, {5'd0, 1'b1, e});
      addStep(doRead, 3, CSR_ADDR, '0, '0);
      addStep(doWrite, 3, TDR_ADDR, {5'd0, e} ^ 16'h00ff, '0);
      addStep(expTx, 3, '0, '0, {5'd0, 1'b1, e});
      addStep(doTxReady, 3, '0, 16'd1, '0);
      addStep(expTx, 3, '0, '0, {5'd0, 1'b0, e});
      addStep(doRead, 3, CSR_ADDR, '0, {1'b0, CSR_IDLE});
      // Test 4 covers the receive interrupt and its rearm after an RBUF read
      addStep(doWrite, 4, CSR_ADDR, 16'(1 << CSR_RIE), '0);
      nextEntry(ent[0]);
      nextEntry(ent[1]);
      addStep(doChar, 4, '0, {5'd0, ent[0]}, '0);
      addStep(expIntr, 4, '0, '0, 17'b10);
      addStep(doIack, 4, '0, '0, '0);
      addStep(doVector, 4, '0, '0, {8'd0, VEC_BASE});
      addStep(expIntr, 4, '0, '0, 17'b00);
      addStep(doChar, 4, '0, {5'd0, ent[1]}, '0);
      addStep(expIntr, 4, '0, '0, 17'b00);
      addStep(doRead, 4, RBUF_ADDR, '0, rbufOf(ent[0]));
      addStep(expIntr, 4, '0, '0, 17'b10);
      addStep(doIack, 4, '0, '0, '0);
      addStep(doVector, 4, '0, '0, {8'd0, VEC_BASE});
      addStep(expIntr, 4, '0, '0, 17'b00);
      addStep(doRead, 4, RBUF_ADDR, '0, rbufOf(ent[1]));
      addStep(expIntr, 4, '0, '0, 17'b00);
      // Test 5 shows receive winning when both pend at iack
      addStep(doWrite, 5, CSR_ADDR, 16'((1 << CSR_TIE) | (1 << CSR_RIE)), '0);
      nextEntry(e);
      addStep(doChar, 5, '0, {5'd0, e}, '0);
      addStep(expIntr, 5, '0, '0, 17'b11);
      addStep(doIack, 5, '0, '0, '0);
      addStep(doVector, 5, '0, '0, {8'd0, VEC_BASE});
      addStep(expIntr, 5, '0, '0, 17'b01);
      addStep(doIack, 5, '0, '0, '0);
      addStep(doVector, 5, '0, '0, {8'd0, VEC_BASE + 9'd4});
      addStep(expIntr, 5, '0, '0, 17'b00);
      addStep(doRead, 5, RBUF_ADDR, '0, rbufOf(e));
      addStep(expIntr, 5, '0, '0, 17'b00);
      // Test 6 shows clear flushing silo, enables and requests
      nextEntry(ent[0]);
      nextEntry(ent[1]);
      addStep(doChar, 6, '0, {5'd0, ent[0]}, '0);
      addStep(doChar, 6, '0, {5'd0, ent[1]}, '0);
      addStep(expIntr, 6, '0, '0, 17'b10);
      addStep(doWrite, 6, CSR_ADDR, 16'(1 << CSR_CLR), '0);
      addStep(doRead, 6, CSR_ADDR, '0, {1'b0, CSR_IDLE});
      addStep(expIntr, 6, '0, '0, 17'b00);
      addStep(doRead, 6, RBUF_ADDR, '0, '0);
   endtask

   ////////////////////////////////////////
   // Bus and line drivers
   ////////////////////////////////////////

   // Advance to 5 ns after the next rising edge
   task automatic nextCycle();
      @(posedge clk);
      #5;
   endtask

   task automatic apbWrite(input regAddrT addr, input logic [15:0] data);
      paddr  = addr;
      pwdata = data;
      pwrite = 1'b1;
      psel   = 1'b1;
      nextCycle();
      penable = 1'b1;
      nextCycle();
      psel    = 1'b0;
      penable = 1'b0;
      pwrite  = 1'b0;
   endtask

   // Checker samples during the access phase
   task automatic apbRead(input regAddrT addr, input logic [16:0] expv);
      paddr  = addr;
      pwrite = 1'b0;
      psel   = 1'b1;
      nextCycle();
      penable = 1'b1;
      rdChk   = 1'b1;
      expVal  = expv;
      nextCycle();
      psel    = 1'b0;
      penable = 1'b0;
      rdChk   = 1'b0;
   endtask

   task automatic sendChar(input siloEntryT e);
      rxValid = 1'b1;
      rxLine  = e.line;
      rxData  = e.data;
      nextCycle();
      rxValid = 1'b0;
   endtask

   task automatic pulseIack();
      iack = 1'b1;
      nextCycle();
      iack = 1'b0;
   endtask

   task automatic readVector(input logic [16:0] expv);
      vectRead = 1'b1;
      vecChk   = 1'b1;
      expVal   = expv;
      nextCycle();
      vectRead = 1'b0;
      vecChk   = 1'b0;
   endtask

   // Bounded wait for the interrupt lines before one checked cycle
   task automatic waitIntr(input logic [16:0] expv);
      int n;
      n = 0;
      while ({rxIntr, txIntr} != expv[1:0] && n < WAIT_LIMIT)
      begin
         nextCycle();
         n++;
      end
      intrChk = 1'b1;
      expVal  = expv;
      nextCycle();
      intrChk = 1'b0;
   endtask

   // Same for the transmit valid flag
   task automatic waitTx(input logic [16:0] expv);
      int n;
      n = 0;
      while (txValid != expv[11] && n < WAIT_LIMIT)
      begin
         nextCycle();
         n++;
      end
      txChk  = 1'b1;
      expVal = expv;
      nextCycle();
      txChk  = 1'b0;
   endtask

   task automatic runStep(input stepT s);
      case (s.kind)
         doWrite:   apbWrite(s.addr, s.data);
         doRead:    apbRead(s.addr, s.expv);
         doChar:    sendChar(siloEntryT'(s.data[10:0]));
         doIack:    pulseIack();
         doVector:  readVector(s.expv);
         expIntr:   waitIntr(s.expv);
         expTx:     waitTx(s.expv);
         default:
         begin
            txReady = s.data[0];
            nextCycle();
         end
      endcase
   endtask

   ////////////////////////////////////////
   // Main sequence
   ////////////////////////////////////////

   initial
   begin
      rst      = 1'b1;
      paddr    = '0;
      psel     = 1'b0;
      penable  = 1'b0;
      pwrite   = 1'b0;
      pwdata   = '0;
      iack     = 1'b0;
      vectRead = 1'b0;
      rxValid  = 1'b0;
      rxLine   = '0;
      rxData   = '0;
      txReady  = 1'b0;
      rdChk    = 1'b0;
      vecChk   = 1'b0;
      intrChk  = 1'b0;
      txChk    = 1'b0;
      expVal   = '0;
      testNum  = '0;
      stepNum  = '0;
      runDone  = 1'b0;
      lcgState = 32'hebdb;
      numChecks = 0;
      buildTable();
      // Eight cycles per step covers the longest bounded wait
      cycleLimit = steps.size() * 8 + 100;
      repeat (10) @(posedge clk);
      #5;
      rst = 1'b0;
      for (int k = 0; k < steps.size(); k++)
      begin
         testNum = steps[k].test;
         stepNum = 32'(k);
         runStep(steps[k]);
      end
      runDone = 1'b1;
      nextCycle();
      while (!reportDone)
         nextCycle();
      $display("summary: %0d tests, %0d checks, %0d errors",
               testCount, checkCount, errorCount);
      if (errorCount == 0 && checkCount == numChecks)
         $display("TB PASSED");
      else
      begin
         if (checkCount != numChecks)
            $display("only %0d of %0d checks were run", checkCount, numChecks);
         $display("TB FAILED");
      end
      $finish;
   end

   // Run length guard
   always @(posedge clk)
   begin
      cycleCount++;
      if (cycleCount > cycleLimit)
      begin
         $display("timeout: run did not finish within %0d cycles", cycleLimit);
         $display("TB FAILED");
         $finish;
      end
   end

endmodule

`default_nettype wire

/* testbench/dzMuxChecker.sv */
////////////////////////////////////////
// DZ multiplexer response checker
// Compares DUT outputs with table values, reports per test
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dzMuxChecker
(
   input  wire                 clk,
   // Watched DUT outputs
   input  wire  [15:0]         prdata,
   input  wire                 pready,
   input  wire                 pslverr,
   input  wire                 txValid,
   input  wire dzPkg::lineT    txLine,
   input  wire dzPkg::charT    txData,
   input  wire                 rxIntr,
   input  wire                 txIntr,
   input  wire  [8:0]          intrVector,
   // Check strobes and expected value from the stimulus table
   input  wire                 rdChk,
   input  wire                 vecChk,
   input  wire                 intrChk,
   input  wire                 txChk,
   input  wire  [16:0]         expVal,
   input  wire  [7:0]          testNum,
   input  wire  [31:0]         stepNum,
   input  wire                 runDone,
   output logic                reportDone,
   output int                  checkCount,
   output int                  errorCount,
   output int                  testCount
);

   int         checks     = 0;
   int         errors     = 0;
   int         tests      = 0;
   int         testChecks = 0;
   int         testErrors = 0;
   logic [7:0] curTest    = 8'd0;
   logic       doneFlag   = 1'b0;
   logic       bad;

   assign reportDone = doneFlag;
   assign checkCount = checks;
   assign errorCount = errors;
   assign testCount  = tests;

   // Print the wrong signal and mark the step as bad
   task automatic reportMismatch(input string sig, input logic [16:0] got,
                                 input logic [16:0] want);
      $display("error test %0d step %0d: %s got %h expected %h",
               testNum, stepNum, sig, got, want);
      bad = 1'b1;
   endtask

   // Summary line of the test that just ended
   task automatic closeTest();
      $display("test %0d done: %0d checks, %0d errors", curTest, testChecks, testErrors);
      tests++;
      testChecks = 0;
      testErrors = 0;
   endtask

   ////////////////////////////////////////
   // Sampling at the clock edge
   ////////////////////////////////////////

   always @(posedge clk)
   begin
      if (rdChk || vecChk || intrChk || txChk)
      begin
         // New test number closes the previous one
         if (testNum != curTest)
         begin
            if (curTest != 8'd0)
               closeTest();
            curTest = testNum;
         end
         bad = 1'b0;
         // APB read data, ready and slave error
         if (rdChk)
         begin
            if (prdata !== expVal[15:0])
               reportMismatch("prdata", {1'b0, prdata}, {1'b0, expVal[15:0]});
            if (pready !== 1'b1)
               reportMismatch("pready", {16'd0, pready}, 17'd1);
            if (pslverr !== expVal[16])
               reportMismatch("pslverr", {16'd0, pslverr}, {16'd0, expVal[16]});
         end
         // Vector during the read cycle
         if (vecChk && intrVector !== expVal[8:0])
            reportMismatch("intrVector", {8'd0, intrVector}, {8'd0, expVal[8:0]});
         if (intrChk)
         begin
            if (rxIntr !== expVal[1])
               reportMismatch("rxIntr", {16'd0, rxIntr}, {16'd0, expVal[1]});
            if (txIntr !== expVal[0])
               reportMismatch("txIntr", {16'd0, txIntr}, {16'd0, expVal[0]});
            // No vector outside the read cycle
            if (intrVector !== 9'd0)
               reportMismatch("intrVector", {8'd0, intrVector}, 17'd0);
         end
         // Line and data of the transmit port are held with the valid flag
         if (txChk)
         begin
            if (txValid !== expVal[11])
               reportMismatch("txValid", {16'd0, txValid}, {16'd0, expVal[11]});
            if (txLine !== expVal[10:8])
               reportMismatch("txLine", {14'd0, txLine}, {14'd0, expVal[10:8]});
            if (txData !== expVal[7:0])
               reportMismatch("txData", {9'd0, txData}, {9'd0, expVal[7:0]});
         end
         checks++;
         testChecks++;
         if (bad)
         begin
            errors++;
            testErrors++;
         end
      end
      // End of table flushes the last test line
      if (runDone && !doneFlag)
      begin
         if (curTest != 8'd0)
            closeTest();
         doneFlag = 1'b1;
      end
   end

endmodule

`default_nettype wire

/* rtl/dzMux.sv */
////////////////////////////////////////
// DZ serial line multiplexer
// Register file, receive silo and interrupt controller
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dzMux
#(
   parameter int         SILO_DEPTH  = 16,
   parameter logic [8:0] VECTOR_BASE = 9'o300
)
(
   input  wire                 clk,
   input  wire                 rst,
   // APB slave
   input  wire dzPkg::regAddrT paddr,
   input  wire                 psel,
   input  wire                 penable,
   input  wire                 pwrite,
   input  wire  [15:0]         pwdata,
   output logic [15:0]         prdata,
   output logic                pready,
   output logic                pslverr,
   // Interrupt bus
   input  wire                 iack,
   input  wire                 vectRead,
   output logic                rxIntr,
   output logic                txIntr,
   output logic [8:0]          intrVector,
   // Line receivers
   input  wire                 rxValid,
   input  wire dzPkg::lineT    rxLine,
   input  wire dzPkg::charT    rxData,
   // Transmitter
   input  wire                 txReady,
   output logic                txValid,
   output dzPkg::lineT         txLine,
   output dzPkg::charT         txData
);

   import dzPkg::*;

   logic      siloEmpty;
   logic      siloPop;
   siloEntryT siloHead;

   // Register file to interrupt controller
   dzIntrIf intrBus ();

   dzRegs dzRegs_i (
      .clk(clk), .rst(rst),
      .paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
      .pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
      .txReady(txReady), .txValid(txValid), .txLine(txLine), .txData(txData),
      .siloEmpty(siloEmpty), .siloHead(siloHead), .siloPop(siloPop),
      .intrIf(intrBus.regs)
   );

   // Flushed by the CSR clear pulse
   dzRxSilo #(.SILO_DEPTH(SILO_DEPTH)) dzRxSilo_i (
      .clk(clk), .rst(rst), .clr(intrBus.clr),
      .push(rxValid), .pushEntry(siloEntryT'({rxLine, rxData})),
      .pop(siloPop), .empty(siloEmpty), .head(siloHead)
   );

   dzIntr #(.VECTOR_BASE(VECTOR_BASE)) dzIntr_i (
      .clk(clk), .rst(rst), .iack(iack), .vectRead(vectRead),
      .rxIntr(rxIntr), .txIntr(txIntr), .intrVector(intrVector),
      .intrIf(intrBus.intr)
   );

endmodule

`default_nettype wire

/* rtl/dzIntr.sv */
////////////////////////////////////////
// DZ interrupt controller
// Receive and transmit request FSMs with vector arbiter
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dzIntr
#(
   parameter logic [8:0] VECTOR_BASE = 9'o300
)
(
   input  wire         clk,
   input  wire         rst,
   input  wire         iack,
   input  wire         vectRead,
   output logic        rxIntr,
   output logic        txIntr,
   output logic [8:0]  intrVector,
   dzIntrIf.intr       intrIf
);

   typedef enum logic [1:0] {rxIdle, rxAct, rxWait, rxDone} rxStateT;
   typedef enum logic [1:0] {txIdle, txAct, txWait} txStateT;
   typedef enum logic [2:0] {
      arbIdle, arbIack, arbVectRead, arbVectClr, arbRxDone, arbTxDone
   } arbStateT;

   rxStateT  rxState;
   txStateT  txState;
   arbStateT arbState;
   logic     commitRx;
   logic     commitTx;
   logic     rxClr;
   logic     txClr;

   ////////////////////////////////////////
   // Receive request
   ////////////////////////////////////////

   // Rearms only after the RBUF read pulse has ended
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         rxState <= rxIdle;
      else if (intrIf.clr)
         rxState <= rxIdle;
      else
      begin
         case (rxState)
            rxIdle: if (intrIf.csrRrdy && intrIf.csrRie) rxState <= rxAct;
            rxAct:  if (rxClr) rxState <= rxWait;
            rxWait: if (intrIf.rbufRead) rxState <= rxDone;
            rxDone: if (!intrIf.rbufRead) rxState <= rxIdle;
            default: rxState <= rxIdle;
         endcase
      end
   end

   // Enable masks the output while the request is kept
   assign rxIntr = (rxState == rxAct) && intrIf.csrRie;

   ////////////////////////////////////////
   // Transmit request
   ////////////////////////////////////////

   // Rearms once TRDY has gone low
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         txState <= txIdle;
      else if (intrIf.clr)
         txState <= txIdle;
      else
      begin
         case (txState)
            txIdle: if (intrIf.csrTrdy && intrIf.csrTie) txState <= txAct;
            txAct:  if (txClr) txState <= txWait;
            txWait: if (!intrIf.csrTrdy) txState <= txIdle;
            default: txState <= txIdle;
         endcase
      end
   end

   assign txIntr = (txState == txAct) && intrIf.csrTie;

   ////////////////////////////////////////
   // Arbiter
   ////////////////////////////////////////

   // Receive wins only if asserted when iack arrives
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         arbState <= arbIdle;
         commitRx <= 1'b0;
         commitTx <= 1'b0;
      end
      else if (intrIf.clr)
      begin
         arbState <= arbIdle;
         commitRx <= 1'b0;
         commitTx <= 1'b0;
      end
      else
      begin
         case (arbState)
            arbIdle:
               if ((rxState == rxAct) || (txState == txAct))
                  arbState <= arbIack;
            arbIack:
               if (iack)
               begin
                  commitRx <= rxIntr;
                  commitTx <= !rxIntr;
                  arbState <= arbVectRead;
               end
            arbVectRead:
               if (vectRead)
                  arbState <= arbVectClr;
            arbVectClr:
               if (!vectRead)
                  arbState <= commitRx ? arbRxDone : arbTxDone;
            default:
            begin
               // Done states release the commit
               commitRx <= 1'b0;
               commitTx <= 1'b0;
               arbState <= arbIdle;
            end
         endcase
      end
   end

   assign rxClr = (arbState == arbRxDone);
   assign txClr = (arbState == arbTxDone);

   // Vector only during the read cycle
   always_comb
   begin
      intrVector = '0;
      if (vectRead && commitRx)
         intrVector = VECTOR_BASE;
      else if (vectRead && commitTx)
         intrVector = VECTOR_BASE + 9'd4;
   end

   // Exactly one committed side holds a live request through the vector cycle
   oneCommit : assert property (@(posedge clk) disable iff (rst)
      (arbState inside {arbVectRead, arbVectClr}) |->
         ((commitRx && (rxState == rxAct)) ^ (commitTx && (txState == txAct))));

endmodule

`default_nettype wire

/* rtl/dzRxSilo.sv */
////////////////////////////////////////
// DZ receive silo
// Circular FIFO of received characters, drops on overflow
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dzRxSilo
#(
   parameter int SILO_DEPTH = 16
)
(
   input  wire                     clk,
   input  wire                     rst,
   input  wire                     clr,
   input  wire                     push,
   input  wire dzPkg::siloEntryT   pushEntry,
   input  wire                     pop,
   output logic                    empty,
   output dzPkg::siloEntryT        head
);

   import dzPkg::*;

   localparam int PTR_W = (SILO_DEPTH > 1) ? $clog2(SILO_DEPTH) : 1;
   localparam int CNT_W = $clog2(SILO_DEPTH + 1);

   // Storage
   siloEntryT        mem [SILO_DEPTH];
   logic [PTR_W-1:0] rdPtr;
   logic [PTR_W-1:0] wrPtr;
   logic [CNT_W-1:0] count;
   logic             full;
   logic             doPush;
   logic             doPop;

   // Pointer advance, wraps at any depth
   function automatic logic [PTR_W-1:0] nextPtr(input logic [PTR_W-1:0] ptr);
      if (ptr == PTR_W'(SILO_DEPTH - 1))
         return '0;
      return ptr + 1'b1;
   endfunction

   assign empty  = (count == '0);
   assign full   = (count == CNT_W'(SILO_DEPTH));
   // Overflow characters are lost
   assign doPush = push && !full;
   assign doPop  = pop && !empty;
   assign head   = mem[rdPtr];

   always_ff @(posedge clk)
   begin
      if (doPush)
         mem[wrPtr] <= pushEntry;
   end

   // Pointers and occupancy, clr flushes
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rdPtr <= '0;
         wrPtr <= '0;
         count <= '0;
      end
      else if (clr)
      begin
         rdPtr <= '0;
         wrPtr <= '0;
         count <= '0;
      end
      else
      begin
         if (doPush)
            wrPtr <= nextPtr(wrPtr);
         if (doPop)
            rdPtr <= nextPtr(rdPtr);
         case ({doPush, doPop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
      end
   end

   // Occupancy bound
   countBound : assert property (@(posedge clk) disable iff (rst)
      count <= CNT_W'(SILO_DEPTH));

endmodule

`default_nettype wire

/* rtl/dzRegs.sv */
////////////////////////////////////////
// DZ register file
// APB slave with CSR, RBUF, TDR and the transmit handshake
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module dzRegs
(
   input  wire                     clk,
   input  wire                     rst,
   // APB slave
   input  wire dzPkg::regAddrT     paddr,
   input  wire                     psel,
   input  wire                     penable,
   input  wire                     pwrite,
   input  wire  [15:0]             pwdata,
   output logic [15:0]             prdata,
   output logic                    pready,
   output logic                    pslverr,
   // Transmit port
   input  wire                     txReady,
   output logic                    txValid,
   output dzPkg::lineT             txLine,
   output dzPkg::charT             txData,
   // Receive silo
   input  wire                     siloEmpty,
   input  wire dzPkg::siloEntryT   siloHead,
   output logic                    siloPop,
   // Interrupt events
   dzIntrIf.regs                   intrIf
);

   import dzPkg::*;

   logic        accessPh;
   logic        rdAccess;
   logic        wrAccess;
   logic        hitCsr;
   logic        hitRbuf;
   logic        hitTdr;
   logic        clrPulse;
   logic        tdrWrite;
   logic        rie;
   logic        tie;
   logic [15:0] csrData;
   logic [15:0] rbufData;
   siloEntryT   tdrEntry;

   ////////////////////////////////////////
   // APB decode
   ////////////////////////////////////////

   // No wait states
   assign pready   = 1'b1;
   assign accessPh = psel && penable && pready;
   assign rdAccess = accessPh && !pwrite;
   assign wrAccess = accessPh && pwrite;

   assign hitCsr  = (paddr == CSR_ADDR);
   assign hitRbuf = (paddr == RBUF_ADDR);
   assign hitTdr  = (paddr == TDR_ADDR);

   // Error for any unmapped offset
   assign pslverr = accessPh && !(hitCsr || hitRbuf || hitTdr);

   // Clear acts on the edge ending the write
   assign clrPulse = wrAccess && hitCsr && pwdata[CSR_CLR];

   // Pop only with data in the silo
   assign siloPop = rdAccess && hitRbuf && !siloEmpty;

   // Second write while TRDY low is ignored
   assign tdrWrite = wrAccess && hitTdr && !txValid;
   assign tdrEntry = siloEntryT'(pwdata[$bits(siloEntryT)-1:0]);

   // Interrupt enables
   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
      begin
         rie <= 1'b0;
         tie <= 1'b0;
      end
      else if (clrPulse)
      begin
         rie <= 1'b0;
         tie <= 1'b0;
      end
      else if (wrAccess && hitCsr)
      begin
         rie <= pwdata[CSR_RIE];
         tie <= pwdata[CSR_TIE];
      end
   end

   ////////////////////////////////////////
   // TDR hold register
   ////////////////////////////////////////

   always_ff @(posedge clk or posedge rst)
   begin
      if (rst)
         txValid <= 1'b0;
      else if (clrPulse)
         txValid <= 1'b0;
      else if (txValid && txReady)
         txValid <= 1'b0;
      else if (tdrWrite)
         txValid <= 1'b1;
   end

   // Character and line load only while empty
   always_ff @(posedge clk)
   begin
      if (tdrWrite)
      begin
         txLine <= tdrEntry.line;
         txData <= tdrEntry.data;
      end
   end

   ////////////////////////////////////////
   // Read data
   ////////////////////////////////////////

   always_comb
   begin
      csrData           = '0;
      csrData[CSR_RIE]  = rie;
      csrData[CSR_RRDY] = !siloEmpty;
      csrData[CSR_TIE]  = tie;
      csrData[CSR_TRDY] = !txValid;
   end

   // RBUF reads zero when nothing is waiting
   always_comb
   begin
      rbufData = '0;
      if (!siloEmpty)
      begin
         rbufData[RBUF_VALID]               = 1'b1;
         rbufData[$bits(siloEntryT)-1:0]    = siloHead;
      end
   end

   always_comb
   begin
      prdata = '0;
      if (psel && !pwrite)
      begin
         case (paddr)
            CSR_ADDR:  prdata = csrData;
            RBUF_ADDR: prdata = rbufData;
            default:   prdata = '0;
         endcase
      end
   end

   // Events toward the interrupt controller
   assign intrIf.csrRie   = rie;
   assign intrIf.csrRrdy  = !siloEmpty;
   assign intrIf.rbufRead = rdAccess && hitRbuf;
   assign intrIf.csrTie   = tie;
   assign intrIf.csrTrdy  = !txValid;
   assign intrIf.clr      = clrPulse;

   // Held character stays put until the transmitter takes it
   txHoldStable : assert property (@(posedge clk) disable iff (rst)
      txValid && !txReady && !clrPulse |=> txValid && $stable(txData) && $stable(txLine));

   // An RBUF read of an empty silo returns zero and pops nothing
   noPopWhenEmpty : assert property (@(posedge clk) disable iff (rst)
      rdAccess && hitRbuf && siloEmpty |-> !siloPop && (prdata == '0));

endmodule

`default_nettype wire

/* rtl/dzIntrIf.sv */
////////////////////////////////////////
// DZ interrupt event interface
// Request and completion events for the interrupt controller
////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface dzIntrIf;

   // Receive side
   logic csrRie;
   logic csrRrdy;
   logic rbufRead;

   // Transmit side
   logic csrTie;
   logic csrTrdy;

   // Controller clear
   logic clr;

   // Register file publishes the events
   modport regs (output csrRie, csrRrdy, rbufRead, csrTie, csrTrdy, clr);

   // Interrupt controller only listens
   modport intr (input csrRie, csrRrdy, rbufRead, csrTie, csrTrdy, clr);

endinterface

`default_nettype wire

/* rtl/dzPkg.sv */
////////////////////////////////////////
// DZ multiplexer shared definitions
// Register map, CSR bit positions and silo entry
////////////////////////////////////////

`default_nettype none

package dzPkg;

   // Line number, eight lines
   typedef logic [2:0] lineT;

   // One received or transmitted character
   typedef logic [7:0] charT;

   // Silo entry, also the low bits of RBUF and TDR
   typedef struct packed {
      lineT line;
      charT data;
   } siloEntryT;

   // APB register offset
   typedef logic [3:0] regAddrT;

   ////////////////////////////////////////
   // Register offsets
   ////////////////////////////////////////

   localparam regAddrT CSR_ADDR  = 4'd0;
   localparam regAddrT RBUF_ADDR = 4'd4;
   localparam regAddrT TDR_ADDR  = 4'd8;

   ////////////////////////////////////////
   // CSR bit positions
   ////////////////////////////////////////

   // Write only, reads back as zero
   localparam int CSR_CLR  = 4;
   localparam int CSR_RIE  = 6;
   // Read only, silo holds a character
   localparam int CSR_RRDY = 7;
   localparam int CSR_TIE  = 14;
   // Read only, TDR hold register empty
   localparam int CSR_TRDY = 15;

   // RBUF data valid flag
   localparam int RBUF_VALID = 15;

endpackage

`default_nettype wire
